/* rtl/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// TLB geometry

// Sets per way
`define TLB_DEPTH 16

// Ways per set, power of two only
`define TLB_WAY_NUM 4

// log2 of the set count
`define TLB_IDX_WIDTH 4

// VPN[1] bits above the index plus all of VPN[0]
`define TLB_TAG_WIDTH 16

// Memory request credits held by the walker after reset
`define MEM_CREDITS 2

`endif

/* rtl/sv32_pkg.sv */
package sv32_pkg;

    // Sv32 addressing
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;

    // VPN[1] in 19:10, VPN[0] in 9:0
    typedef logic [19:0] vpn_t;

    // PPN[1] in 21:10, PPN[0] in 9:0
    typedef logic [21:0] ppn_t;

    // Raw PTE, PPN sits in 31:10
    typedef logic [31:0] pte_t;

    // Flag positions inside a PTE
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_X = 3;

    // TLB set index and stored tag
    typedef logic [15:0] tlb_tag_t;
    typedef logic [3:0]  tlb_idx_t;

endpackage

/* rtl/mmu_ctrl_pkg.sv */
package mmu_ctrl_pkg;

    // Translation sequencer
    typedef enum logic [1:0] {
        XLAT_IDLE,
        XLAT_LOOKUP,
        XLAT_WALK,
        XLAT_RESPOND
    } xlat_state_t;

    // Two-level page-table walker
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_REQ_L1,
        WALK_WAIT_L1,
        WALK_REQ_L0,
        WALK_WAIT_L0,
        WALK_DONE
    } walk_state_t;

endpackage

/* rtl/tlb.sv */
`timescale 1ns/100ps
`include "mmu_macros.svh"

module tlb
    import sv32_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic cs,
    input  logic we,
    input  vpn_t vpn,
    input  logic spage_in,
    input  pte_t pte_in,
    input  logic flush_req,
    output logic pte_hit,
    output logic spage_out,
    output pte_t pte_out
);

    localparam int ORD_W = $clog2(`TLB_WAY_NUM);
    localparam logic [ORD_W-1:0] MRU = ORD_W'(`TLB_WAY_NUM - 1);

    tlb_idx_t idx;
    tlb_idx_t idx_q;
    tlb_tag_t tag_in;
    tlb_tag_t tag_q;
    logic     cs_q;
    logic     wr;
    logic     promote;

    logic [`TLB_DEPTH-1:0] valid [`TLB_WAY_NUM];
    logic [`TLB_DEPTH-1:0] spg   [`TLB_WAY_NUM];
    logic [ORD_W-1:0]      order [`TLB_WAY_NUM][`TLB_DEPTH];

    logic [`TLB_WAY_NUM-1:0] hit;
    logic [`TLB_WAY_NUM-1:0] victim;
    logic                    spg_q   [`TLB_WAY_NUM];
    pte_t                    way_pte [`TLB_WAY_NUM];
    logic [ORD_W-1:0]        victim_order;
    logic [ORD_W-1:0]        hit_order;

    assign idx     = vpn[10 +: `TLB_IDX_WIDTH];
    // Megapage entries keep VPN[0] out of the tag
    assign tag_in  = {vpn[19:10+`TLB_IDX_WIDTH], vpn[9:0] & {10{~spage_in}}};
    assign wr      = cs && we;
    assign promote = cs_q && pte_hit;
    assign pte_hit = |hit;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cs_q <= 1'b0;
        end else begin
            cs_q <= cs && !we;
        end
    end

    // Lookup context for the cycle after the lookup edge
    always_ff @(posedge clk) begin
        idx_q <= idx;
        tag_q <= {vpn[19:10+`TLB_IDX_WIDTH], vpn[9:0]};
    end

    always_comb begin
        victim_order = '0;
        hit_order    = '0;
        for (int w = 0; w < `TLB_WAY_NUM; w++) begin
            if (victim[w]) begin
                victim_order = victim_order | order[w][idx];
            end
            if (hit[w]) begin
                hit_order = hit_order | order[w][idx_q];
            end
        end
    end

    always_comb begin
        pte_out   = '0;
        spage_out = 1'b0;
        for (int w = 0; w < `TLB_WAY_NUM; w++) begin
            if (hit[w]) begin
                pte_out   = pte_out | way_pte[w];
                spage_out = spage_out | spg_q[w];
            end
        end
        // Put the requested VPN[0] back into PPN[0] of a megapage
        if (spage_out) begin
            pte_out[19:10] = pte_out[19:10] | tag_q[9:0];
        end
    end

    for (genvar g = 0; g < `TLB_WAY_NUM; g++) begin : g_way
        tlb_tag_t tag_mem [`TLB_DEPTH];
        pte_t     pte_mem [`TLB_DEPTH];
        tlb_tag_t tag_rd;
        logic     valid_q;

        // Only the way holding order 0 takes the fill
        assign victim[g] = wr && (order[g][idx] == '0);
        assign hit[g]    = cs_q && valid_q &&
                           (tag_rd == {tag_q[`TLB_TAG_WIDTH-1:10],
                                       tag_q[9:0] & {10{~spg_q[g]}}});

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid[g] <= '0;
                spg[g]   <= '0;
                for (int i = 0; i < `TLB_DEPTH; i++) begin
                    order[g][i] <= ORD_W'(g);
                end
            end else if (flush_req) begin
                valid[g] <= '0;
                for (int i = 0; i < `TLB_DEPTH; i++) begin
                    order[g][i] <= ORD_W'(g);
                end
            end else if (wr) begin
                if (victim[g]) begin
                    valid[g][idx] <= 1'b1;
                    spg[g][idx]   <= spage_in;
                    order[g][idx] <= MRU;
                end else if (order[g][idx] > victim_order) begin
                    order[g][idx] <= order[g][idx] - 1'b1;
                end
            end else if (promote) begin
                if (hit[g]) begin
                    order[g][idx_q] <= MRU;
                end else if (order[g][idx_q] > hit_order) begin
                    order[g][idx_q] <= order[g][idx_q] - 1'b1;
                end
            end
        end

        // A flush on the lookup edge already forces a miss
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= valid[g][idx] && !flush_req;
            end
        end

        always_ff @(posedge clk) begin
            if (victim[g]) begin
                tag_mem[idx] <= tag_in;
                pte_mem[idx] <= pte_in;
            end
            tag_rd     <= tag_mem[idx];
            way_pte[g] <= pte_mem[idx];
            spg_q[g]   <= spg[g][idx];
        end
    end

endmodule

/* rtl/page_walker.sv */
`timescale 1ns/100ps
`include "mmu_macros.svh"

module page_walker
    import sv32_pkg::*;
    import mmu_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  ppn_t   satp_ppn,
    input  logic   walk_start,
    input  vpn_t   walk_vpn,
    output logic   walk_done,
    output logic   walk_fault,
    output pte_t   walk_pte,
    output logic   walk_mega,
    output logic   mem_req_valid,
    output paddr_t mem_req_addr,
    input  logic   mem_credit,
    input  logic   mem_rsp_valid,
    input  pte_t   mem_rsp_data
);

    localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

    walk_state_t       state;
    logic [CRED_W-1:0] credits;
    vpn_t              vpn_q;
    pte_t              pte_q;
    logic              rsp_leaf;

    assign rsp_leaf = mem_rsp_data[PTE_R] || mem_rsp_data[PTE_X];

    // Hold in the request state until memory hands back a credit
    assign mem_req_valid = ((state == WALK_REQ_L1) || (state == WALK_REQ_L0)) &&
                           (credits != '0);

    // Level 0 goes through the PPN of the level-1 pointer
    assign mem_req_addr = (state == WALK_REQ_L1) ?
                          {satp_ppn, vpn_q[19:10], 2'b00} :
                          {pte_q[31:10], vpn_q[9:0], 2'b00};

    assign walk_done = (state == WALK_DONE);
    assign walk_pte  = pte_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= CRED_W'(`MEM_CREDITS);
        end else begin
            credits <= credits + CRED_W'(mem_credit) - CRED_W'(mem_req_valid);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= WALK_IDLE;
            walk_fault <= 1'b0;
            walk_mega  <= 1'b0;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (walk_start) begin
                        walk_fault <= 1'b0;
                        walk_mega  <= 1'b0;
                        state      <= WALK_REQ_L1;
                    end
                end
                WALK_REQ_L1: begin
                    if (mem_req_valid) begin
                        state <= WALK_WAIT_L1;
                    end
                end
                WALK_WAIT_L1: begin
                    if (mem_rsp_valid) begin
                        if (!mem_rsp_data[PTE_V]) begin
                            walk_fault <= 1'b1;
                            state      <= WALK_DONE;
                        end else if (rsp_leaf) begin
                            // Megapage must have PPN[0] clear
                            walk_mega  <= 1'b1;
                            walk_fault <= (mem_rsp_data[19:10] != '0);
                            state      <= WALK_DONE;
                        end else begin
                            state <= WALK_REQ_L0;
                        end
                    end
                end
                WALK_REQ_L0: begin
                    if (mem_req_valid) begin
                        state <= WALK_WAIT_L0;
                    end
                end
                WALK_WAIT_L0: begin
                    if (mem_rsp_valid) begin
                        walk_fault <= !mem_rsp_data[PTE_V] || !rsp_leaf;
                        state      <= WALK_DONE;
                    end
                end
                default: begin
                    state <= WALK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == WALK_IDLE) && walk_start) begin
            vpn_q <= walk_vpn;
        end
        if (((state == WALK_WAIT_L1) || (state == WALK_WAIT_L0)) && mem_rsp_valid) begin
            pte_q <= mem_rsp_data;
        end
    end

endmodule

/* rtl/xlat_ctrl.sv */
`timescale 1ns/100ps

module xlat_ctrl
    import sv32_pkg::*;
    import mmu_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   req_valid,
    input  vaddr_t req_vaddr,
    output logic   xlat_credit,
    output logic   rsp_valid,
    output paddr_t rsp_paddr,
    output logic   rsp_fault,
    output logic   tlb_cs,
    output logic   tlb_we,
    output vpn_t   tlb_vpn,
    output logic   tlb_spage_in,
    output pte_t   tlb_pte_in,
    input  logic   tlb_hit,
    input  logic   tlb_spage_out,
    input  pte_t   tlb_pte_out,
    output logic   walk_start,
    output vpn_t   walk_vpn,
    input  logic   walk_done,
    input  logic   walk_fault,
    input  pte_t   walk_pte,
    input  logic   walk_mega
);

    xlat_state_t state;
    vaddr_t      vaddr_q;
    logic        refill_q;
    logic        init_q;

    // Megapage takes PPN[0] from VPN[0] of the request
    function automatic paddr_t form_paddr(pte_t pte, logic mega, vaddr_t va);
        ppn_t ppn;
        ppn = pte[31:10];
        if (mega) begin
            ppn[9:0] = va[21:12];
        end
        return {ppn, va[11:0]};
    endfunction

    // Lookup goes out on the request edge itself
    assign tlb_vpn      = (state == XLAT_IDLE) ? req_vaddr[31:12] : vaddr_q[31:12];
    assign tlb_we       = (state == XLAT_RESPOND) && refill_q;
    assign tlb_cs       = ((state == XLAT_IDLE) && req_valid) || tlb_we;
    assign tlb_pte_in   = walk_pte;
    assign tlb_spage_in = walk_mega;
    assign walk_vpn     = vaddr_q[31:12];
    assign rsp_valid    = (state == XLAT_RESPOND);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= XLAT_IDLE;
            walk_start  <= 1'b0;
            refill_q    <= 1'b0;
            init_q      <= 1'b1;
            xlat_credit <= 1'b0;
        end else begin
            init_q      <= 1'b0;
            xlat_credit <= init_q || (state == XLAT_RESPOND);
            walk_start  <= (state == XLAT_LOOKUP) && !tlb_hit;
            case (state)
                XLAT_IDLE:    if (req_valid) state <= XLAT_LOOKUP;
                XLAT_LOOKUP: begin
                    refill_q <= 1'b0;
                    state    <= tlb_hit ? XLAT_RESPOND : XLAT_WALK;
                end
                XLAT_WALK: begin
                    if (walk_done) begin
                        refill_q <= !walk_fault;
                        state    <= XLAT_RESPOND;
                    end
                end
                default:      state <= XLAT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == XLAT_IDLE) && req_valid) begin
            vaddr_q <= req_vaddr;
        end
        if ((state == XLAT_LOOKUP) && tlb_hit) begin
            rsp_paddr <= form_paddr(tlb_pte_out, tlb_spage_out, vaddr_q);
            rsp_fault <= 1'b0;
        end else if ((state == XLAT_WALK) && walk_done) begin
            rsp_paddr <= walk_fault ? '0 : form_paddr(walk_pte, walk_mega, vaddr_q);
            rsp_fault <= walk_fault;
        end
    end

endmodule

/* rtl/mmu_top.sv */
`timescale 1ns/100ps

module mmu_top
    import sv32_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  ppn_t   satp_ppn,
    input  logic   flush_req,
    input  logic   req_valid,
    input  vaddr_t req_vaddr,
    output logic   xlat_credit,
    output logic   rsp_valid,
    output paddr_t rsp_paddr,
    output logic   rsp_fault,
    output logic   mem_req_valid,
    output paddr_t mem_req_addr,
    input  logic   mem_credit,
    input  logic   mem_rsp_valid,
    input  pte_t   mem_rsp_data
);

    logic tlb_cs;
    logic tlb_we;
    vpn_t tlb_vpn;
    logic tlb_spage_in;
    pte_t tlb_pte_in;
    logic tlb_hit;
    logic tlb_spage_out;
    pte_t tlb_pte_out;

    logic walk_start;
    vpn_t walk_vpn;
    logic walk_done;
    logic walk_fault;
    pte_t walk_pte;
    logic walk_mega;

    xlat_ctrl i_xlat_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_vaddr     (req_vaddr),
        .xlat_credit   (xlat_credit),
        .rsp_valid     (rsp_valid),
        .rsp_paddr     (rsp_paddr),
        .rsp_fault     (rsp_fault),
        .tlb_cs        (tlb_cs),
        .tlb_we        (tlb_we),
        .tlb_vpn       (tlb_vpn),
        .tlb_spage_in  (tlb_spage_in),
        .tlb_pte_in    (tlb_pte_in),
        .tlb_hit       (tlb_hit),
        .tlb_spage_out (tlb_spage_out),
        .tlb_pte_out   (tlb_pte_out),
        .walk_start    (walk_start),
        .walk_vpn      (walk_vpn),
        .walk_done     (walk_done),
        .walk_fault    (walk_fault),
        .walk_pte      (walk_pte),
        .walk_mega     (walk_mega)
    );

    tlb i_tlb (
        .clk       (clk),
        .rstn      (rstn),
        .cs        (tlb_cs),
        .we        (tlb_we),
        .vpn       (tlb_vpn),
        .spage_in  (tlb_spage_in),
        .pte_in    (tlb_pte_in),
        .flush_req (flush_req),
        .pte_hit   (tlb_hit),
        .spage_out (tlb_spage_out),
        .pte_out   (tlb_pte_out)
    );

    page_walker i_page_walker (
        .clk           (clk),
        .rstn          (rstn),
        .satp_ppn      (satp_ppn),
        .walk_start    (walk_start),
        .walk_vpn      (walk_vpn),
        .walk_done     (walk_done),
        .walk_fault    (walk_fault),
        .walk_pte      (walk_pte),
        .walk_mega     (walk_mega),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

/* tb/pt_memory_model.sv */
`timescale 1ns/100ps

module pt_memory_model
    import sv32_pkg::*;
#(
    parameter int LATENCY = 3,
    parameter int WORDS   = 16384
)
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   hold_credit,
    input  logic   req_valid,
    input  paddr_t req_addr,
    output logic   credit,
    output logic   rsp_valid,
    output pte_t   rsp_data
);

    localparam int AW = $clog2(WORDS);

    pte_t          mem    [WORDS];
    logic          pipe_v [LATENCY];
    logic [AW-1:0] pipe_a [LATENCY];
    int            held;

    // Empty memory reads as invalid PTEs
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    task automatic write_word(input paddr_t addr, input pte_t data);
        mem[addr[AW+1:2]] = data;
    endtask

    // Requests move through a fixed delay line, answered in order
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < LATENCY; i++) begin
                pipe_v[i] <= 1'b0;
                pipe_a[i] <= '0;
            end
            credit <= 1'b0;
            held   <= 0;
        end else begin
            pipe_v[0] <= req_valid;
            pipe_a[0] <= req_addr[AW+1:2];
            for (int i = 1; i < LATENCY; i++) begin
                pipe_v[i] <= pipe_v[i-1];
                pipe_a[i] <= pipe_a[i-1];
            end
            // Credit goes back one cycle after the response unless held
            if (hold_credit) begin
                credit <= 1'b0;
                held   <= held + int'(rsp_valid);
            end else if (held > 0) begin
                // Held credits drain one per cycle
                credit <= 1'b1;
                held   <= held - 1 + int'(rsp_valid);
            end else begin
                credit <= rsp_valid;
            end
        end
    end

    assign rsp_valid = pipe_v[LATENCY-1];
    assign rsp_data  = mem[pipe_a[LATENCY-1]];

endmodule

/* tb/tb_mmu.sv */
`timescale 1ns/100ps
`include "mmu_macros.svh"

module tb_mmu
    import sv32_pkg::*;
;

    localparam ppn_t ROOT_PPN       = 22'd1;
    localparam int   CREDIT_TIMEOUT = 50;
    localparam int   RSP_TIMEOUT    = 200;

    logic   clk;
    logic   rstn;
    ppn_t   satp_ppn;
    logic   flush_req;
    logic   req_valid;
    vaddr_t req_vaddr;
    logic   xlat_credit;
    logic   rsp_valid;
    paddr_t rsp_paddr;
    logic   rsp_fault;
    logic   mem_req_valid;
    paddr_t mem_req_addr;
    logic   mem_credit;
    logic   mem_rsp_valid;
    pte_t   mem_rsp_data;
    logic   hold_credit;

    int     cycle;
    int     req_credits;
    int     mem_credits;
    int     mem_req_count;
    int     walk_reqs;
    int     req_cycle;
    int     rsp_cycle;
    bit     rsp_seen;
    bit     exp_pending;
    bit     exp_fault;
    paddr_t exp_paddr;
    paddr_t exp_l1_addr;
    paddr_t exp_l0_addr;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     next_table;
    int     l0_table [1024];

    // Reference map of installed translations
    vpn_t map_vpn   [$];
    ppn_t map_ppn   [$];
    bit   map_mega  [$];
    bit   map_fault [$];

    mmu_top i_dut (
        .clk           (clk),
        .rstn          (rstn),
        .satp_ppn      (satp_ppn),
        .flush_req     (flush_req),
        .req_valid     (req_valid),
        .req_vaddr     (req_vaddr),
        .xlat_credit   (xlat_credit),
        .rsp_valid     (rsp_valid),
        .rsp_paddr     (rsp_paddr),
        .rsp_fault     (rsp_fault),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    pt_memory_model i_mem (
        .clk         (clk),
        .rstn        (rstn),
        .hold_credit (hold_credit),
        .req_valid   (mem_req_valid),
        .req_addr    (mem_req_addr),
        .credit      (mem_credit),
        .rsp_valid   (mem_rsp_valid),
        .rsp_data    (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Credit counters and response checks, sampled on the rising edge
    always @(posedge clk) begin
        if (!rstn) begin
            cycle         = 0;
            req_credits   = 0;
            mem_credits   = `MEM_CREDITS;
            mem_req_count = 0;
        end else begin
            cycle++;
            if (req_valid) begin
                checks++;
                assert (req_credits > 0) else begin
                    $display("Translation request sent without a credit");
                    errors++;
                end
                req_credits--;
                req_cycle = cycle;
            end
            if (xlat_credit) begin
                checks++;
                assert (req_credits == 0) else begin
                    $display("Translation credit granted while one is still held");
                    errors++;
                end
                req_credits++;
            end
            if (mem_req_valid) begin
                checks += 2;
                assert (mem_credits > 0) else begin
                    $display("Memory request issued with no memory credit left");
                    errors++;
                end
                if (walk_reqs == 0) begin
                    assert (mem_req_addr == exp_l1_addr) else
                        report_value("mem_req_addr", exp_l1_addr, mem_req_addr);
                end else begin
                    assert (mem_req_addr == exp_l0_addr) else
                        report_value("mem_req_addr", exp_l0_addr, mem_req_addr);
                end
                walk_reqs++;
                mem_credits--;
                mem_req_count++;
            end
            if (mem_credit) begin
                mem_credits++;
            end
            if (rsp_valid) begin
                checks += 2;
                assert (exp_pending) else begin
                    $display("Response arrived with no translation pending");
                    errors++;
                end
                assert (rsp_fault == exp_fault) else
                    report_value("rsp_fault", exp_fault, rsp_fault);
                if (!exp_fault) begin
                    checks++;
                    assert (rsp_paddr == exp_paddr) else
                        report_value("rsp_paddr", exp_paddr, rsp_paddr);
                end
                exp_pending = 1'b0;
                rsp_seen    = 1'b1;
                rsp_cycle   = cycle;
            end
        end
    end

    function automatic logic [9:0] pick_vpn1(input logic [3:0] idx);
        logic [31:0] r;
        r = $urandom;
        return {r[5:0], idx};
    endfunction

    function automatic logic [9:0] pick_vpn0();
        logic [31:0] r;
        r = $urandom;
        return r[9:0];
    endfunction

    function automatic logic [11:0] pick_offset();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    function automatic ppn_t pick_ppn();
        logic [31:0] r;
        r = $urandom;
        return r[21:0];
    endfunction

    task automatic add_entry(input vpn_t vpn, input ppn_t ppn, input bit mega, input bit fault);
        map_vpn.push_back(vpn);
        map_ppn.push_back(ppn);
        map_mega.push_back(mega);
        map_fault.push_back(fault);
    endtask

    // Unmapped addresses fault, megapages match on VPN[1] only
    function automatic void ref_translate(input vaddr_t va, output paddr_t pa, output bit fault);
        vpn_t vpn;
        vpn   = va[31:12];
        pa    = '0;
        fault = 1'b1;
        for (int i = 0; i < map_vpn.size(); i++) begin
            if (map_mega[i] ? (map_vpn[i][19:10] == vpn[19:10]) : (map_vpn[i] == vpn)) begin
                fault = map_fault[i];
                pa    = map_mega[i] ? {map_ppn[i][21:10], vpn[9:0], va[11:0]} :
                                      {map_ppn[i], va[11:0]};
            end
        end
    endfunction

    task automatic set_l1(input logic [9:0] vpn1, input pte_t pte);
        i_mem.write_word({ROOT_PPN, vpn1, 2'b00}, pte);
    endtask

    task automatic map_page(input vpn_t vpn, input ppn_t ppn, input bit valid);
        ppn_t table_ppn;
        if (l0_table[vpn[19:10]] == 0) begin
            l0_table[vpn[19:10]] = next_table;
            set_l1(vpn[19:10], {ppn_t'(next_table), 10'h001});
            next_table++;
        end
        table_ppn = ppn_t'(l0_table[vpn[19:10]]);
        i_mem.write_word({table_ppn, vpn[9:0], 2'b00}, valid ? {ppn, 10'h003} : 32'h0);
        add_entry(vpn, ppn, 1'b0, !valid);
    endtask

    // Leaf at level 1, misaligned when PPN[0] is nonzero
    task automatic map_megapage(input logic [9:0] vpn1, input ppn_t ppn);
        set_l1(vpn1, {ppn, 10'h003});
        add_entry({vpn1, 10'h000}, ppn, 1'b1, ppn[9:0] != 10'h000);
    endtask

    task automatic translate(input vaddr_t va, input int exp_reqs, input bit exp_hit);
        int start_reqs;
        int wait_cnt;
        ref_translate(va, exp_paddr, exp_fault);
        // Walk addresses from the root table and the level-0 table layout
        exp_l1_addr = {ROOT_PPN, va[31:22], 2'b00};
        exp_l0_addr = {ppn_t'(l0_table[va[31:22]]), va[21:12], 2'b00};
        walk_reqs   = 0;
        wait_cnt = 0;
        while (req_credits == 0) begin
            if (wait_cnt == CREDIT_TIMEOUT) begin
                fail_timeout("a translation credit");
            end
            @(negedge clk);
            wait_cnt++;
        end
        start_reqs  = mem_req_count;
        rsp_seen    = 1'b0;
        exp_pending = 1'b1;
        req_valid   = 1'b1;
        req_vaddr   = va;
        @(negedge clk);
        req_valid = 1'b0;
        wait_cnt  = 0;
        while (!rsp_seen) begin
            if (wait_cnt == RSP_TIMEOUT) begin
                fail_timeout("a translation response");
            end
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_hit) begin
            checks++;
            assert (rsp_cycle - req_cycle == 2) else
                report_value("rsp_valid latency", 2, rsp_cycle - req_cycle);
        end
        checks++;
        assert (mem_req_count - start_reqs == exp_reqs) else
            report_value("mem_req_valid count", exp_reqs, mem_req_count - start_reqs);
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", num, name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    initial begin
        int         seed_val;
        int         err_before;
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        ppn_t       ppn;
        vaddr_t     va_page;
        vaddr_t     va_l1;
        vaddr_t     va_l0;
        vaddr_t     va_mis;
        vaddr_t     lru_va [5];

        seed_val     = $urandom(32'hb356e47b);
        rstn         = 1'b0;
        satp_ppn     = ROOT_PPN;
        flush_req    = 1'b0;
        req_valid    = 1'b0;
        req_vaddr    = '0;
        hold_credit  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        walk_reqs    = 0;
        exp_pending  = 1'b0;
        rsp_seen     = 1'b0;
        next_table   = 2;
        for (int i = 0; i < 1024; i++) begin
            l0_table[i] = 0;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        // 4 KB page, two-level walk
        err_before = errors;
        vpn1 = pick_vpn1(4'h1);
        vpn0 = pick_vpn0();
        map_page({vpn1, vpn0}, pick_ppn(), 1'b1);
        va_page = {vpn1, vpn0, pick_offset()};
        translate(va_page, 2, 1'b0);
        end_test(1, "page miss", err_before);

        err_before = errors;
        translate({vpn1, vpn0, pick_offset()}, 0, 1'b1);
        end_test(2, "page hit", err_before);

        // Two pages inside one 4 MB region
        err_before = errors;
        vpn1 = pick_vpn1(4'h3);
        ppn  = pick_ppn();
        map_megapage(vpn1, {ppn[21:10], 10'h000});
        vpn0 = pick_vpn0();
        translate({vpn1, vpn0, pick_offset()}, 1, 1'b0);
        translate({vpn1, vpn0 ^ 10'h2a5, pick_offset()}, 0, 1'b1);
        end_test(3, "megapage", err_before);

        err_before = errors;
        vpn1 = pick_vpn1(4'h5);
        set_l1(vpn1, 32'h0);
        va_l1 = {vpn1, pick_vpn0(), pick_offset()};
        vpn1 = pick_vpn1(4'h6);
        vpn0 = pick_vpn0();
        map_page({vpn1, vpn0}, pick_ppn(), 1'b0);
        va_l0 = {vpn1, vpn0, pick_offset()};
        vpn1 = pick_vpn1(4'h7);
        ppn  = pick_ppn();
        map_megapage(vpn1, {ppn[21:10], ppn[9:0] | 10'h001});
        va_mis = {vpn1, pick_vpn0(), pick_offset()};
        // Second pass must walk again
        for (int k = 0; k < 2; k++) begin
            translate(va_l1, 1, 1'b0);
            translate(va_l0, 2, 1'b0);
            translate(va_mis, 1, 1'b0);
        end
        end_test(4, "faults", err_before);

        // Five pages in set 9, four ways
        err_before = errors;
        vpn1 = pick_vpn1(4'h9);
        vpn0 = pick_vpn0();
        // Credits withheld by memory stall the second walk
        hold_credit = 1'b1;
        fork
            begin
                for (int k = 0; k < 5; k++) begin
                    map_page({vpn1, vpn0 ^ 10'(k)}, pick_ppn(), 1'b1);
                    lru_va[k] = {vpn1, vpn0 ^ 10'(k), pick_offset()};
                    translate(lru_va[k], 2, 1'b0);
                end
            end
            begin
                repeat (40) @(negedge clk);
                hold_credit = 1'b0;
            end
        join
        translate(lru_va[0], 2, 1'b0);
        translate(lru_va[4], 0, 1'b1);
        end_test(5, "lru", err_before);

        err_before = errors;
        translate(va_page, 0, 1'b1);
        flush_req = 1'b1;
        @(negedge clk);
        flush_req = 1'b0;
        translate(va_page, 2, 1'b0);
        translate(va_page, 0, 1'b1);
        end_test(6, "flush", err_before);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+rtl
rtl/sv32_pkg.sv
rtl/mmu_ctrl_pkg.sv
rtl/tlb.sv
rtl/page_walker.sv
rtl/xlat_ctrl.sv
rtl/mmu_top.sv
tb/pt_memory_model.sv
tb/tb_mmu.sv
